/* acs_matrix.f */
rtl/viterbi_pkg.sv
rtl/acs_unit.sv
rtl/acs_column.sv
rtl/symbol_skew.sv
rtl/decision_align.sv
rtl/acs_matrix.sv
verification/tb_acs_matrix.sv

/* Makefile */
# Verilator build and run for the ACS trellis testbench

VERILATOR ?= verilator
TOP       ?= tb_acs_matrix
FILELIST  ?= acs_matrix.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/acs_matrix_stim.txt */
# one block per line, all fields hex
# id s0 s1 s2 s3 s4 s5 s6 s7 pm0 pm1 pm2 pm3 dec(col7..col0)
0 0 0 0 0 0 0 0 0 00 03 02 03 00000444
1 3 2 0 1 1 3 3 2 03 00 03 02 00f20481
2 3 2 0 0 1 3 3 2 04 01 04 03 00124481
3 3 1 2 2 2 2 2 2 03 02 03 00 fff8d821
4 1 1 2 2 2 2 0 2 03 02 03 02 de8d8d72
5 3 3 3 3 3 3 3 3 03 03 02 03 11111111
6 0 0 3 2 3 3 2 3 00 03 02 03 f0010144
7 2 0 3 2 3 3 2 3 01 04 03 04 101b81e8

# second pass, same blocks in another order and with other ids
0 1 1 2 2 2 2 0 2 03 02 03 02 de8d8d72
1 0 0 0 0 0 0 0 0 00 03 02 03 00000444
2 2 0 3 2 3 3 2 3 01 04 03 04 101b81e8
3 3 2 0 0 1 3 3 2 04 01 04 03 00124481
4 3 3 3 3 3 3 3 3 03 03 02 03 11111111
5 3 2 0 1 1 3 3 2 03 00 03 02 00f20481
6 3 1 2 2 2 2 2 2 03 02 03 00 fff8d821
7 0 0 3 2 3 3 2 3 00 03 02 03 f0010144
2 3 1 2 2 2 2 2 2 03 02 03 00 fff8d821
5 0 0 3 2 3 3 2 3 00 03 02 03 f0010144

/* verification/tb_acs_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_acs_matrix import viterbi_pkg::*; ();

	localparam int    NUM_COLS      = 8;
	localparam int    BURST_LEN     = 8;
	localparam int    DRAIN_TIMEOUT = 200;
	localparam string STIM_FILE     = "verification/acs_matrix_stim.txt";

	typedef struct packed {
		logic [ID_WIDTH-1:0]                id;
		logic [NUM_COLS-1:0][SYM_WIDTH-1:0] sym;
		pm_t  [NUM_STATES-1:0]              pm;
		dec_t [NUM_COLS-1:0]                dec;
	} block_t;

	logic                               clk;
	logic                               rst_n;
	logic                               in_valid;
	logic [ID_WIDTH-1:0]                in_id;
	logic [NUM_COLS-1:0][SYM_WIDTH-1:0] in_symbols;
	logic                               out_valid;
	logic [ID_WIDTH-1:0]                out_id;
	pm_t  [NUM_STATES-1:0]              out_pm;
	dec_t [NUM_COLS-1:0]                out_dec;

	block_t     stim_q [$];
	block_t     exp_q [$];
	int         accept_q [$];
	int         cycle = 0;
	int         sent;
	int         received;
	int         value_errs;
	int         timing_errs;
	int         other_errs;
	logic [7:0] lfsr;

	acs_matrix #(
		.NUM_COLS (NUM_COLS)
	) u_acs_matrix (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_id      (in_id),
		.in_symbols (in_symbols),
		.out_valid  (out_valid),
		.out_id     (out_id),
		.out_pm     (out_pm),
		.out_dec    (out_dec)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 8'hb8;
		end
		return state >> 1;
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [31:0] v [14];
		block_t      b;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() == 0 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6],
				v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
			if (n == 14) begin
				b.id = v[0][ID_WIDTH-1:0];
				for (int k = 0; k < NUM_COLS; k++) begin
					b.sym[k] = v[1 + k][SYM_WIDTH-1:0];
				end
				for (int s = 0; s < NUM_STATES; s++) begin
					b.pm[s] = v[9 + s][PM_WIDTH-1:0];
				end
				b.dec = v[13];
				stim_q.push_back(b);
			end else if (n > 0) begin
				$display("malformed stimulus line: %s", line);
				other_errs++;
			end
		end
		$fclose(fd);
	endtask

	// output side, sampled half a cycle away from the driving edge
	always @(negedge clk) begin
		block_t exp;
		int     acc;

		if (out_valid) begin
			assert (exp_q.size() > 0 && accept_q.size() > 0) else begin
				$display("out_valid went high with no block in flight");
				other_errs++;
			end
			if (exp_q.size() > 0 && accept_q.size() > 0) begin
				exp = exp_q.pop_front();
				acc = accept_q.pop_front();
				received++;
				assert (cycle - acc == NUM_COLS) else begin
					$display("ERROR out_valid latency exp %h got %h", NUM_COLS, cycle - acc);
					timing_errs++;
				end
				assert (out_id == exp.id) else begin
					$display("ERROR out_id exp %h got %h", exp.id, out_id);
					value_errs++;
				end
				for (int s = 0; s < NUM_STATES; s++) begin
					assert (out_pm[s] == exp.pm[s]) else begin
						$display("ERROR out_pm[%0d] exp %h got %h (id %h)",
							s, exp.pm[s], out_pm[s], exp.id);
						value_errs++;
					end
				end
				assert (out_dec == exp.dec) else begin
					$display("ERROR out_dec exp %h got %h (id %h)", exp.dec, out_dec, exp.id);
					value_errs++;
				end
			end
		end
		if (rst_n && in_valid) begin
			accept_q.push_back(cycle);
		end
	end

	initial begin
		int gap;
		int t;

		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_id       = '0;
		in_symbols  = '0;
		lfsr        = 8'd66;
		sent        = 0;
		received    = 0;
		value_errs  = 0;
		timing_errs = 0;
		other_errs  = 0;

		load_stimulus();
		assert (stim_q.size() > 0) else begin
			$display("no blocks read from the stimulus file");
			other_errs++;
		end

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// idle stretch so a stray out_valid after reset gets caught
		repeat (NUM_COLS + 4) @(posedge clk);

		// first blocks go back to back and fill the pipeline
		foreach (stim_q[i]) begin
			gap = 0;
			if (i >= BURST_LEN) begin
				draw_bits(2, gap);
			end
			repeat (gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(posedge clk);
			in_valid   <= 1'b1;
			in_id      <= stim_q[i].id;
			in_symbols <= stim_q[i].sym;
			exp_q.push_back(stim_q[i]);
			sent++;
		end
		@(posedge clk);
		in_valid <= 1'b0;

		for (t = 0; t < DRAIN_TIMEOUT && exp_q.size() != 0; t++) begin
			@(posedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d blocks never left the pipeline", exp_q.size());
			other_errs++;
		end

		repeat (NUM_COLS + 2) @(posedge clk);

		$display("blocks sent %0d, received %0d; value %0d, timing %0d, other %0d failures",
			sent, received, value_errs, timing_errs, other_errs);
		if (value_errs + timing_errs + other_errs == 0 && received == sent) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/acs_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

module acs_matrix import viterbi_pkg::*; #(
	parameter int NUM_COLS = 8
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               in_valid,
	input  logic [ID_WIDTH-1:0]                in_id,
	input  logic [NUM_COLS-1:0][SYM_WIDTH-1:0] in_symbols,
	output logic                               out_valid,
	output logic [ID_WIDTH-1:0]                out_id,
	output pm_t  [NUM_STATES-1:0]              out_pm,
	output dec_t [NUM_COLS-1:0]                out_dec
);

	logic [NUM_COLS-1:0][SYM_WIDTH-1:0] col_symbols;
	col_bus_t                           col_bus [NUM_COLS+1];
	dec_t [NUM_COLS-1:0]                col_dec;

	// metrics grow by at most 2 per column and are never renormalized
	if (2 * NUM_COLS >= 2 ** PM_WIDTH) begin : g_width_check
		$error("acs_matrix: %0d columns overflow a %0d-bit metric", NUM_COLS, PM_WIDTH);
	end

	symbol_skew #(
		.NUM_COLS (NUM_COLS)
	) u_symbol_skew (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_symbols  (in_symbols),
		.col_symbols (col_symbols)
	);

	// every path starts from metric zero
	assign col_bus[0] = '{valid: in_valid, id: in_id, pm: '0};

	for (genvar k = 0; k < NUM_COLS; k++) begin : g_col
		acs_column #(
			.COL (k)
		) u_acs_column (
			.clk     (clk),
			.rst_n   (rst_n),
			.symbol  (col_symbols[k]),
			.bus_in  (col_bus[k]),
			.bus_out (col_bus[k+1]),
			.dec     (col_dec[k])
		);
	end

	decision_align #(
		.NUM_COLS (NUM_COLS)
	) u_decision_align (
		.clk         (clk),
		.rst_n       (rst_n),
		.col_dec     (col_dec),
		.aligned_dec (out_dec)
	);

	assign out_valid = col_bus[NUM_COLS].valid;
	assign out_id    = col_bus[NUM_COLS].id;
	assign out_pm    = col_bus[NUM_COLS].pm;

	// a block leaves NUM_COLS cycles after it enters, with its own id
	a_block_out: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(in_valid, NUM_COLS) |-> out_valid && out_id == $past(in_id, NUM_COLS)
	) else $error("acs_matrix: block lost or id mismatch, out_id = %0h", out_id);

	// nothing appears without a matching input
	a_no_spurious: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, NUM_COLS)
	) else $error("acs_matrix: out_valid without an accepted block");

endmodule

`default_nettype wire

/* rtl/decision_align.sv */
`timescale 1ns/1ps
`default_nettype none

module decision_align import viterbi_pkg::*; #(
	parameter int NUM_COLS = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  dec_t [NUM_COLS-1:0] col_dec,
	output dec_t [NUM_COLS-1:0] aligned_dec
);

	// early columns hold their decisions until the last column catches up
	for (genvar k = 0; k < NUM_COLS; k++) begin : g_col
		localparam int DEPTH = NUM_COLS - 1 - k;

		if (DEPTH == 0) begin : g_last
			assign aligned_dec[k] = col_dec[k];
		end else begin : g_line
			dec_t taps [DEPTH];

			// column k is k+1 stages in, so the line must supply the rest
			if ($size(taps) + k + 1 != NUM_COLS) begin : g_depth_check
				$error("decision_align: column %0d has depth %0d", k, $size(taps));
			end

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int i = 0; i < DEPTH; i++) begin
						taps[i] <= '0;
					end
				end else begin
					taps[0] <= col_dec[k];
					for (int i = 1; i < DEPTH; i++) begin
						taps[i] <= taps[i-1];
					end
				end
			end

			assign aligned_dec[k] = taps[DEPTH-1];
		end
	end

endmodule

`default_nettype wire

/* rtl/symbol_skew.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_skew import viterbi_pkg::*; #(
	parameter int NUM_COLS = 8
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [NUM_COLS-1:0][SYM_WIDTH-1:0] in_symbols,
	output logic [NUM_COLS-1:0][SYM_WIDTH-1:0] col_symbols
);

	// symbol k waits k cycles for its block to reach column k
	for (genvar k = 0; k < NUM_COLS; k++) begin : g_col
		if (k == 0) begin : g_direct
			assign col_symbols[k] = in_symbols[k];
		end else begin : g_line
			logic [SYM_WIDTH-1:0] taps [k];

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int i = 0; i < k; i++) begin
						taps[i] <= '0;
					end
				end else begin
					taps[0] <= in_symbols[k];
					for (int i = 1; i < k; i++) begin
						taps[i] <= taps[i-1];
					end
				end
			end

			assign col_symbols[k] = taps[k-1];
		end
	end

endmodule

`default_nettype wire

/* rtl/acs_column.sv */
`timescale 1ns/1ps
`default_nettype none

module acs_column import viterbi_pkg::*; #(
	parameter int COL = 0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [SYM_WIDTH-1:0] symbol,
	input  col_bus_t             bus_in,
	output col_bus_t             bus_out,
	output dec_t                 dec
);

	pm_t [NUM_STATES-1:0] pm_next;
	dec_t                 dec_next;

	for (genvar s = 0; s < NUM_STATES; s++) begin : g_state
		// even predecessor of state s is 2 * s[0]
		localparam int EVEN = 2 * (s % 2);

		acs_unit #(
			.STATE (trellis_state_t'(s))
		) u_acs_unit (
			.symbol   (symbol),
			.pm_even  (bus_in.pm[EVEN]),
			.pm_odd   (bus_in.pm[EVEN + 1]),
			.pm_new   (pm_next[s]),
			.decision (dec_next[s])
		);

		// one symbol adds at most 2, so after COL+1 columns the bound is 2*(COL+1)
		a_pm_bound: assert property (
			@(posedge clk) disable iff (!rst_n)
			bus_out.valid |-> int'(bus_out.pm[s]) <= 2 * (COL + 1)
		) else $error("acs_column %0d: pm[%0d] = %0d out of range", COL, s, bus_out.pm[s]);
	end

	// metrics and decisions only load on a valid slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_out <= '0;
			dec     <= '0;
		end else begin
			bus_out.valid <= bus_in.valid;
			if (bus_in.valid) begin
				bus_out.id <= bus_in.id;
				bus_out.pm <= pm_next;
				dec        <= dec_next;
			end
		end
	end

	a_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(bus_out.valid)
	) else $error("acs_column %0d: valid is unknown", COL);

endmodule

`default_nettype wire

/* rtl/acs_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module acs_unit import viterbi_pkg::*; #(
	parameter trellis_state_t STATE = ST_00
) (
	input  logic [SYM_WIDTH-1:0] symbol,
	input  pm_t                  pm_even,
	input  pm_t                  pm_odd,
	output pm_t                  pm_new,
	output logic                 decision
);

	localparam logic [1:0] S = STATE;

	// both predecessors carry our low bit as their high bit
	localparam trellis_state_t PRED_EVEN = trellis_state_t'({S[0], 1'b0});
	localparam trellis_state_t PRED_ODD  = trellis_state_t'({S[0], 1'b1});
	localparam logic           IN_BIT    = S[1];

	logic [SYM_WIDTH-1:0] diff_even;
	logic [SYM_WIDTH-1:0] diff_odd;
	logic [1:0]           bm_even;
	logic [1:0]           bm_odd;
	pm_t                  sum_even;
	pm_t                  sum_odd;

	// hamming branch metrics
	assign diff_even = symbol ^ expected_symbol(PRED_EVEN, IN_BIT);
	assign diff_odd  = symbol ^ expected_symbol(PRED_ODD, IN_BIT);
	assign bm_even   = 2'($countones(diff_even));
	assign bm_odd    = 2'($countones(diff_odd));

	// add
	assign sum_even = pm_even + pm_t'(bm_even);
	assign sum_odd  = pm_odd + pm_t'(bm_odd);

	// compare, exact tie stays on the even path
	assign decision = (sum_odd < sum_even);

	// select
	assign pm_new = decision ? sum_odd : sum_even;

endmodule

`default_nettype wire

/* rtl/viterbi_pkg.sv */
`default_nettype none

package viterbi_pkg;

	parameter int PM_WIDTH   = 7;
	parameter int SYM_WIDTH  = 2;
	parameter int ID_WIDTH   = 3;
	parameter int NUM_STATES = 4;

	// upper bit of the new state is the input bit just shifted in
	typedef enum logic [1:0] {
		ST_00 = 2'b00,
		ST_01 = 2'b01,
		ST_10 = 2'b10,
		ST_11 = 2'b11
	} trellis_state_t;

	typedef logic [PM_WIDTH-1:0] pm_t;

	// one decision bit per state, 1 means the odd predecessor won
	typedef logic [NUM_STATES-1:0] dec_t;

	typedef struct packed {
		logic                  valid;
		logic [ID_WIDTH-1:0]   id;
		pm_t [NUM_STATES-1:0]  pm;
	} col_bus_t;

	// encoder output for generators 7 and 5 octal
	function automatic logic [SYM_WIDTH-1:0] expected_symbol(
		input trellis_state_t pred,
		input logic           in_bit
	);
		logic [1:0] p;
		logic       g7;
		logic       g5;

		p  = pred;
		g7 = in_bit ^ p[1] ^ p[0];
		g5 = in_bit ^ p[0];
		return {g7, g5};
	endfunction

endpackage

`default_nettype wire
